// File: verilog/arith_core_config.svh
// Immediate arithmetic core configuration
`ifndef ARITH_CORE_CONFIG_SVH
`define ARITH_CORE_CONFIG_SVH

// Widths
`define INSTR_W    32
`define OPCODE_W   10
`define IMM_W      12
`define REG_IDX_W  5
`define DATA_W     64
`define FLAGS_W    4
`define BUS_DATA_W 32
`define BUS_ADR_W  9

// Register file, register 31 is hardwired to zero
`define NUM_REGS   32
`define REG_ZERO   5'd31

// LEGv8 immediate-class opcodes
`define OP_ADDI    10'b1001000100
`define OP_ADDIS   10'b1011000100
`define OP_SUBI    10'b1101000100
`define OP_SUBIS   10'b1111000100
`define OP_ANDI    10'b1001001000
`define OP_ANDIS   10'b1111001000
`define OP_ORRI    10'b1011001000
`define OP_EORI    10'b1101001000

// Byte address map
`define ADR_INSTR    9'h000
`define ADR_STATUS   9'h000
`define ADR_REG_BASE 9'h100

`endif

// File: verilog/arith_core_pkg.sv
// Immediate arithmetic core types
`include "arith_core_config.svh"

package arith_core_pkg;

    // Raw 32-bit instruction word as written by the host
    typedef logic [`INSTR_W-1:0] instr_t;

    // Opcode field, bits 31 to 22 of the instruction
    typedef logic [`OPCODE_W-1:0] opcode_t;

    // Register index for Rn and Rd
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // Register file and ALU word
    typedef logic [`DATA_W-1:0] data_t;

    // Zero-extended immediate field
    typedef logic [`IMM_W-1:0] imm_t;

    // NZCV, N in the top bit
    typedef logic [`FLAGS_W-1:0] flags_t;

    // Wishbone data word
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;

    // Wishbone byte address
    typedef logic [`BUS_ADR_W-1:0] bus_adr_t;

    // ALU function select, codes follow the original datapath table
    //   000 and, 001 or, 010 add, 011 xor
    // 100 and 101 stay reserved for the shifts of the full datapath
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_XOR = 3'b011,
        ALU_SUB = 3'b110
    } alu_fn_t;

    // Bit positions of the NZCV flags
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

endpackage

// File: verilog/arith_bus_port.sv
// Wishbone slave port
`timescale 1ns/1ns
`include "arith_core_config.svh"

module arith_bus_port import arith_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_adr_t  adr,
    input  bus_data_t dat_w,
    input  logic      busy,
    input  flags_t    status_flags,
    input  logic      status_illegal,
    input  data_t     bus_reg_data,
    output logic      ack,
    output bus_data_t dat_r,
    output logic      issue_valid,
    output instr_t    issue_instr,
    output reg_idx_t  bus_reg_addr
);

    logic      req;
    logic      is_reg;
    logic      reg_hi;
    bus_adr_t  reg_off;
    bus_data_t read_word;

    // New request, the ack cycle itself never starts another
    assign req = cyc && stb && !ack;

    // Register window: base + idx*8, +4 selects the upper half
    assign reg_off      = adr - `ADR_REG_BASE;
    assign is_reg       = (adr >= `ADR_REG_BASE) && (adr[1:0] == 2'b00);
    assign reg_hi       = reg_off[2];
    assign bus_reg_addr = reg_off[7:3];

    always_comb begin
        read_word = '0;
        if (is_reg) begin
            read_word = reg_hi ? bus_reg_data[63:32] : bus_reg_data[31:0];
        end else if (adr == `ADR_STATUS) begin
            // Busy on top, sticky illegal below it, NZCV at the bottom
            read_word = {busy, status_illegal, {(`BUS_DATA_W-6){1'b0}}, status_flags};
        end
    end

    // Single-cycle ack one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            ack         <= req;
            // Instruction issues in the ack cycle
            issue_valid <= req && we && (adr == `ADR_INSTR);
        end
    end

    // Data words, only looked at together with ack or issue_valid
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r       <= we ? '0 : read_word;
            issue_instr <= dat_w;
        end
    end

    // Ack spacing gives the pipeline its back-pressure
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) ack |=> !ack
    );

endmodule

// File: verilog/imm_arith_decoder.sv
// Immediate class decoder
`timescale 1ns/1ns
`include "arith_core_config.svh"

module imm_arith_decoder import arith_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue_valid,
    input  instr_t   issue_instr,
    output logic     ctl_valid,
    output alu_fn_t  ctl_alu_fn,
    output imm_t     ctl_imm,
    output reg_idx_t ctl_rn,
    output reg_idx_t ctl_rd,
    output logic     ctl_reg_write,
    output logic     ctl_status_load,
    output logic     illegal_pulse
);

    opcode_t  op;
    imm_t     imm;
    reg_idx_t rn;
    reg_idx_t rd;

    alu_fn_t  dec_fn;
    logic     dec_known;
    logic     dec_s;

    // Fixed field layout
    assign {op, imm, rn, rd} = issue_instr;

    // Opcode match
    always_comb begin
        dec_fn    = ALU_ADD;
        dec_known = 1'b1;
        dec_s     = 1'b0;
        case (op)
            `OP_ADDI: begin
                dec_fn = ALU_ADD;
            end
            `OP_ADDIS: begin
                dec_fn = ALU_ADD;
                dec_s  = 1'b1;
            end
            `OP_SUBI: begin
                dec_fn = ALU_SUB;
            end
            `OP_SUBIS: begin
                dec_fn = ALU_SUB;
                dec_s  = 1'b1;
            end
            `OP_ANDI: begin
                dec_fn = ALU_AND;
            end
            `OP_ANDIS: begin
                dec_fn = ALU_AND;
                dec_s  = 1'b1;
            end
            `OP_ORRI: begin
                dec_fn = ALU_OR;
            end
            `OP_EORI: begin
                dec_fn = ALU_XOR;
            end
            default: begin
                // Unknown, pass through as a no-op
                dec_known = 1'b0;
            end
        endcase
    end

    // Control bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl_valid       <= 1'b0;
            ctl_reg_write   <= 1'b0;
            ctl_status_load <= 1'b0;
            illegal_pulse   <= 1'b0;
        end else begin
            ctl_valid       <= issue_valid;
            // Writes to the zero register are dropped here
            ctl_reg_write   <= issue_valid && dec_known && (rd != `REG_ZERO);
            ctl_status_load <= issue_valid && dec_known && dec_s;
            illegal_pulse   <= issue_valid && !dec_known;
        end
    end

    // Control word payload
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ctl_alu_fn <= dec_fn;
            ctl_imm    <= imm;
            ctl_rn     <= rn;
            ctl_rd     <= rd;
        end
    end

endmodule

// File: verilog/arith_execute.sv
// Execute stage with ALU and flags
`timescale 1ns/1ns
`include "arith_core_config.svh"

module arith_execute import arith_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ctl_valid,
    input  alu_fn_t  ctl_alu_fn,
    input  imm_t     ctl_imm,
    input  reg_idx_t ctl_rn,
    input  reg_idx_t ctl_rd,
    input  logic     ctl_reg_write,
    input  logic     ctl_status_load,
    input  data_t    rd_data,
    output reg_idx_t rd_addr,
    output logic     res_valid,
    output reg_idx_t res_rd,
    output data_t    res_value,
    output logic     res_write,
    output flags_t   res_flags,
    output logic     res_flags_load
);

    data_t         op_a;
    data_t         op_b;
    data_t         op_b_eff;
    logic [64:0]   sum;
    data_t         alu_out;
    flags_t        alu_flags;
    logic          is_arith;

    // Rn read, the zero register is handled in the register file
    assign rd_addr = ctl_rn;

    assign op_a = rd_data;
    // Immediate is zero-extended
    assign op_b = {{(`DATA_W-`IMM_W){1'b0}}, ctl_imm};

    assign is_arith = (ctl_alu_fn == ALU_ADD) || (ctl_alu_fn == ALU_SUB);

    // Subtract as a + ~b + 1
    assign op_b_eff = (ctl_alu_fn == ALU_SUB) ? ~op_b : op_b;
    assign sum = {1'b0, op_a} + {1'b0, op_b_eff} + {64'd0, (ctl_alu_fn == ALU_SUB)};

    always_comb begin
        case (ctl_alu_fn)
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            default: alu_out = sum[63:0];
        endcase
    end

    // NZCV
    always_comb begin
        alu_flags         = '0;
        alu_flags[FLAG_N] = alu_out[63];
        alu_flags[FLAG_Z] = (alu_out == '0);
        if (is_arith) begin
            // Carry out, for SUB this is the no-borrow bit
            alu_flags[FLAG_C] = sum[64];
            // Operands agree in sign, result does not
            alu_flags[FLAG_V] = (op_a[63] == op_b_eff[63]) && (alu_out[63] != op_a[63]);
        end
    end

    // Result control bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid      <= 1'b0;
            res_write      <= 1'b0;
            res_flags_load <= 1'b0;
        end else begin
            res_valid      <= ctl_valid;
            res_write      <= ctl_valid && ctl_reg_write;
            res_flags_load <= ctl_valid && ctl_status_load;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (ctl_valid) begin
            res_rd    <= ctl_rd;
            res_value <= alu_out;
            res_flags <= alu_flags;
        end
    end

    // No forwarding path, so Rn must never hit an uncommitted write
    no_raw_hazard: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctl_valid |-> !(res_valid && res_write && (res_rd == ctl_rn))
    );

endmodule

// File: verilog/arith_result.sv
// Register file and flags
`timescale 1ns/1ns
`include "arith_core_config.svh"

module arith_result import arith_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_addr,
    input  logic     res_valid,
    input  reg_idx_t res_rd,
    input  data_t    res_value,
    input  logic     res_write,
    input  flags_t   res_flags,
    input  logic     res_flags_load,
    input  logic     illegal_pulse,
    input  reg_idx_t bus_reg_addr,
    output data_t    rd_data,
    output data_t    bus_reg_data,
    output flags_t   status_flags,
    output logic     status_illegal
);

    // Only 31 registers are stored
    data_t regs [0:`NUM_REGS-2];

    // Both read ports see zero for register 31
    assign rd_data      = (rd_addr == `REG_ZERO) ? '0 : regs[rd_addr];
    assign bus_reg_data = (bus_reg_addr == `REG_ZERO) ? '0 : regs[bus_reg_addr];

    // Commit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS-1; i++) begin
                regs[i] <= '0;
            end
        end else if (res_valid && res_write && (res_rd != `REG_ZERO)) begin
            regs[res_rd] <= res_value;
        end
    end

    // Flags and the sticky illegal bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_flags   <= '0;
            status_illegal <= 1'b0;
        end else begin
            if (res_valid && res_flags_load) begin
                status_flags <= res_flags;
            end
            // Only reset clears it
            if (illegal_pulse) begin
                status_illegal <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/arith_core_top.sv
// Immediate arithmetic core
`timescale 1ns/1ns
`include "arith_core_config.svh"

module arith_core_top import arith_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_adr_t  adr,
    input  bus_data_t dat_w,
    output bus_data_t dat_r,
    output logic      ack
);

    // Bus port to decoder
    logic     issue_valid;
    instr_t   issue_instr;

    // Decoder to execute
    logic     ctl_valid;
    alu_fn_t  ctl_alu_fn;
    imm_t     ctl_imm;
    reg_idx_t ctl_rn;
    reg_idx_t ctl_rd;
    logic     ctl_reg_write;
    logic     ctl_status_load;
    logic     illegal_pulse;

    // Execute to result
    reg_idx_t rd_addr;
    data_t    rd_data;
    logic     res_valid;
    reg_idx_t res_rd;
    data_t    res_value;
    logic     res_write;
    flags_t   res_flags;
    logic     res_flags_load;

    // Result to bus port
    flags_t   status_flags;
    logic     status_illegal;
    reg_idx_t bus_reg_addr;
    data_t    bus_reg_data;
    logic     busy;

    // Any instruction still in the pipe
    assign busy = ctl_valid || res_valid;

    arith_bus_port u_bus_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_w          (dat_w),
        .busy           (busy),
        .status_flags   (status_flags),
        .status_illegal (status_illegal),
        .bus_reg_data   (bus_reg_data),
        .ack            (ack),
        .dat_r          (dat_r),
        .issue_valid    (issue_valid),
        .issue_instr    (issue_instr),
        .bus_reg_addr   (bus_reg_addr)
    );

    imm_arith_decoder u_decoder (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue_valid     (issue_valid),
        .issue_instr     (issue_instr),
        .ctl_valid       (ctl_valid),
        .ctl_alu_fn      (ctl_alu_fn),
        .ctl_imm         (ctl_imm),
        .ctl_rn          (ctl_rn),
        .ctl_rd          (ctl_rd),
        .ctl_reg_write   (ctl_reg_write),
        .ctl_status_load (ctl_status_load),
        .illegal_pulse   (illegal_pulse)
    );

    arith_execute u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctl_valid       (ctl_valid),
        .ctl_alu_fn      (ctl_alu_fn),
        .ctl_imm         (ctl_imm),
        .ctl_rn          (ctl_rn),
        .ctl_rd          (ctl_rd),
        .ctl_reg_write   (ctl_reg_write),
        .ctl_status_load (ctl_status_load),
        .rd_data         (rd_data),
        .rd_addr         (rd_addr),
        .res_valid       (res_valid),
        .res_rd          (res_rd),
        .res_value       (res_value),
        .res_write       (res_write),
        .res_flags       (res_flags),
        .res_flags_load  (res_flags_load)
    );

    arith_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_addr        (rd_addr),
        .res_valid      (res_valid),
        .res_rd         (res_rd),
        .res_value      (res_value),
        .res_write      (res_write),
        .res_flags      (res_flags),
        .res_flags_load (res_flags_load),
        .illegal_pulse  (illegal_pulse),
        .bus_reg_addr   (bus_reg_addr),
        .rd_data        (rd_data),
        .bus_reg_data   (bus_reg_data),
        .status_flags   (status_flags),
        .status_illegal (status_illegal)
    );

endmodule

// File: tb/arith_core_checker.sv
// Bus response checker
`timescale 1ns/1ns
`include "arith_core_config.svh"

module arith_core_checker import arith_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_adr_t  adr,
    input  bus_data_t dat_r,
    input  logic      ack,
    output int        mismatch_count,
    output int        protocol_count,
    output int        ack_count
);

    // Expected transactions, consumed one per ack
    logic      exp_we [$];
    bus_adr_t  exp_adr [$];
    bus_data_t exp_dat [$];
    int        next_idx;

    // Request as it was presented on the bus
    logic      req_we;
    bus_adr_t  req_adr;
    int        wait_cycles;

    task automatic read_expected();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("tb/arith_core_input.txt", "r");
        if (fd == 0) begin
            $display("Checker cannot open the input file tb/arith_core_input.txt");
            protocol_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%c %h %h", kind, a, d);
            if (n == 3 && (kind == "W" || kind == "R")) begin
                exp_we.push_back(kind == "W");
                exp_adr.push_back(a[`BUS_ADR_W-1:0]);
                exp_dat.push_back(d);
            end
        end
        $fclose(fd);
    endtask

    // Pair this ack with the next line of the file
    task automatic compare_ack();
        if (next_idx >= exp_we.size()) begin
            $display("Acknowledge seen with no transaction left in the input file");
            protocol_count++;
            return;
        end
        ack_count++;
        if (req_we != exp_we[next_idx] || req_adr != exp_adr[next_idx]) begin
            $display("Acknowledged %s at address %h, but the input file expects %s at %h",
                     req_we ? "W" : "R", req_adr,
                     exp_we[next_idx] ? "W" : "R", exp_adr[next_idx]);
            protocol_count++;
        end else if (!req_we && dat_r !== exp_dat[next_idx]) begin
            $display("** Error: dat_r = %h, expected %h (read of address %h)",
                     dat_r, exp_dat[next_idx], req_adr);
            mismatch_count++;
        end
        next_idx++;
    endtask

    initial begin
        mismatch_count = 0;
        protocol_count = 0;
        ack_count = 0;
        next_idx = 0;
        wait_cycles = 0;
        req_we = 1'b0;
        req_adr = '0;
        read_expected();
    end

    // Pre-edge values, ack and dat_r are registered in the DUT
    always @(posedge clk) begin
        if (rst_n) begin
            if (ack) begin
                compare_ack();
            end
            if (cyc && stb && !ack) begin
                req_we = we;
                req_adr = adr;
                wait_cycles++;
                // Ack is due one cycle after the request
                if (wait_cycles == 2) begin
                    $display("No acknowledge for the request at address %h", adr);
                    protocol_count++;
                end
            end else begin
                wait_cycles = 0;
            end
        end
    end

endmodule

// File: tb/arith_core_tb.sv
// Immediate arithmetic core testbench
`timescale 1ns/1ns
`include "arith_core_config.svh"

module arith_core_tb;

    logic                   clk;
    logic                   rst_n;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`BUS_ADR_W-1:0]  adr;
    logic [`BUS_DATA_W-1:0] dat_w;
    logic [`BUS_DATA_W-1:0] dat_r;
    logic                   ack;

    // Transactions in file order
    logic                   txn_we [$];
    logic [`BUS_ADR_W-1:0]  txn_adr [$];
    logic [`BUS_DATA_W-1:0] txn_dat [$];

    int cycle_count = 0;
    int cycle_limit = 100;
    int tb_errors = 0;
    int mismatch_count;
    int protocol_count;
    int ack_count;

    arith_core_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    arith_core_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_r          (dat_r),
        .ack            (ack),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .ack_count      (ack_count)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // One line per transaction: kind, hex address, hex data
    task automatic load_transactions();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("tb/arith_core_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the input file tb/arith_core_input.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%c %h %h", kind, a, d);
            // Comment and blank lines fail the scan
            if (n == 3 && (kind == "W" || kind == "R")) begin
                txn_we.push_back(kind == "W");
                txn_adr.push_back(a[`BUS_ADR_W-1:0]);
                txn_dat.push_back(d);
            end
        end
        $fclose(fd);
    endtask

    task automatic print_counts();
        $display("Errors: %0d read mismatches, %0d bus protocol, %0d testbench",
                 mismatch_count, protocol_count, tb_errors);
    endtask

    // Run limit scales with the number of transactions
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            print_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int   gap;
        logic prev_we;
        gap = $urandom(32'h10ce_7a23);
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        prev_we = 1'b0;
        load_transactions();
        cycle_limit = 100 + 12 * txn_we.size();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < txn_we.size(); i++) begin
            // Writes follow writes at full rate, dependent ones included
            if (txn_we[i] && prev_we) begin
                gap = 0;
            end else begin
                gap = $urandom % 4;
            end
            // A read starts no earlier than 3 cycles after a write ack
            if (!txn_we[i] && prev_we) begin
                gap = gap + 2;
            end
            repeat (gap) @(negedge clk);
            @(negedge clk);
            cyc = 1'b1;
            stb = 1'b1;
            we = txn_we[i];
            adr = txn_adr[i];
            dat_w = txn_we[i] ? txn_dat[i] : '0;
            do @(negedge clk); while (!ack);
            cyc = 1'b0;
            stb = 1'b0;
            we = 1'b0;
            prev_we = txn_we[i];
        end
        repeat (4) @(negedge clk);
        if (ack_count != txn_we.size()) begin
            $display("Only %0d of %0d transactions were acknowledged", ack_count, txn_we.size());
            tb_errors++;
        end
        print_counts();
        if (mismatch_count + protocol_count + tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/arith_core_input.txt
# kind adr data: W writes data to adr, R reads adr and expects data
# adr and data in hex, register n at 100 + 8n, +4 for the upper half
W 000 91048FE1  ADDI X1, XZR, #0x123
W 000 D1049022  SUBI X2, X1, #0x124
W 000 91000843  ADDI X3, X2, #2
R 110 FFFFFFFF  X2 low
R 114 FFFFFFFF  X2 high
R 118 00000001  X3 low
R 000 00000000  status
W 000 B1000444  ADDIS X4, X2, #1
R 000 00000006  Z and C
W 000 F1049025  SUBIS X5, X1, #0x124
R 000 00000008  N, borrow
W 000 F1008C26  SUBIS X6, X1, #0x23
R 130 00000100  X6 low
W 000 91000448  ADDI X8, X2, #1
R 000 00000002  flags kept
W 000 922AF049  ANDI X9, X2, #0xABC
W 000 B2150D2A  ORRI X10, X9, #0x543
W 000 D203C04B  EORI X11, X2, #0xF0
W 000 F2150D2C  ANDIS X12, X9, #0x543
R 150 00000FFF  X10 low
R 158 FFFFFF0F  X11 low
R 000 00000004  Z only
W 000 9100143F  ADDI XZR, X1, #5
R 1F8 00000000  XZR low
W 000 8B000021  not in the immediate class
R 108 00000123  X1 low
R 000 40000004  sticky illegal
W 000 911FFFED  ADDI X13, XZR, #0x7FF
W 000 912005AE  ADDI X14, X13, #0x801
R 170 00001000  X14 low

// File: arith_core_top.f
+incdir+verilog
verilog/arith_core_pkg.sv
verilog/arith_bus_port.sv
verilog/imm_arith_decoder.sv
verilog/arith_execute.sv
verilog/arith_result.sv
verilog/arith_core_top.sv
tb/arith_core_checker.sv
tb/arith_core_tb.sv

// File: Bender.yml
package:
  name: arith_core

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/arith_core_pkg.sv
      - verilog/arith_bus_port.sv
      - verilog/imm_arith_decoder.sv
      - verilog/arith_execute.sv
      - verilog/arith_result.sv
      - verilog/arith_core_top.sv
  - target: test
    files:
      - tb/arith_core_checker.sv
      - tb/arith_core_tb.sv
